// ==== verilog/tlu_pkg.sv ====
`default_nettype none

package tlu_pkg;

    localparam logic [7:0] tlu_version = 8'd1;

    // bus and data widths
    localparam int addr_width = 16;
    localparam int data_width = 8;
    localparam int word_width = 32;
    localparam int reg_count = 16;

    localparam int fifo_depth = 8;
    localparam int fifo_addr_width = 3;
    localparam int sync_stages = 3;

    // register map
    localparam logic [addr_width-1:0] addr_soft_rst = 16'd0;
    localparam logic [addr_width-1:0] addr_conf_mode = 16'd1;
    localparam logic [addr_width-1:0] addr_conf_input = 16'd2;
    localparam logic [addr_width-1:0] addr_low_timeout = 16'd3;
    // first byte of four with the LSB first
    localparam logic [addr_width-1:0] addr_trigger_number = 16'd4;
    localparam logic [addr_width-1:0] addr_set_number = 16'd8;
    localparam logic [addr_width-1:0] addr_lost_count = 16'd12;

    // handshake_alt is the old data handshake code and runs as simple handshake
    typedef enum logic [1:0] {
        mode_disabled = 2'd0,
        mode_no_handshake = 2'd1,
        mode_simple_handshake = 2'd2,
        mode_handshake_alt = 2'd3
    } tlu_mode_e;

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_wait_low = 2'd1,
        st_timeout_hold = 2'd2
    } trigger_state_e;

    typedef struct packed {
        logic [6:0] pad;
        tlu_mode_e mode;
        logic disable_veto;
        logic write_timestamp;
        logic enable_reset;
        logic invert_lemo;
        logic [7:0] low_timeout;
        logic set_number_strobe;
    } tlu_conf_t;

    typedef struct packed {
        logic [word_width-1:0] trigger_number;
        logic [7:0] lost_count;
    } tlu_status_t;

endpackage

`default_nettype wire

// ==== verilog/tlu_bus_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlu_bus_regs import tlu_pkg::*;
(
    input wire BUS_CLK,
    input wire RST,
    input wire [addr_width-1:0] bus_add,
    input wire [data_width-1:0] bus_data_in,
    input wire bus_wr,
    input wire bus_rd,
    output logic [data_width-1:0] bus_data_out,
    input wire tlu_status_t status,
    output tlu_conf_t conf,
    output logic [word_width-1:0] set_value,
    output logic core_rst
);

    logic [data_width-1:0] regs [reg_count];
    logic soft_rst_q;
    logic set_strobe_q;
    logic [word_width-1:0] trig_snap;

    // soft reset lands one cycle after the write to address 0
    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            soft_rst_q <= 1'b0;
        else
            soft_rst_q <= bus_wr && (bus_add == addr_soft_rst);
    end

    assign core_rst = RST | soft_rst_q;

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
        begin
            for (int i = 0; i < reg_count; i++)
                regs[i] <= '0;
            set_strobe_q <= 1'b0;
        end
        else
        begin
            if (bus_wr && (bus_add < addr_width'(reg_count)))
                regs[bus_add[$clog2(reg_count)-1:0]] <= bus_data_in;
            // commit after the top byte is stored
            set_strobe_q <= bus_wr && (bus_add == addr_set_number + 16'd3);
        end
    end

    assign set_value = {regs[11], regs[10], regs[9], regs[8]};

    assign conf = '{
        pad: '0,
        mode: tlu_mode_e'(regs[1][1:0]),
        disable_veto: regs[1][3],
        write_timestamp: regs[1][7],
        enable_reset: regs[2][5],
        invert_lemo: regs[2][6],
        low_timeout: regs[3],
        set_number_strobe: set_strobe_q
    };

    // bytes 5 to 7 come from the copy taken at address 4
    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
            trig_snap <= '0;
        else if (bus_add == addr_trigger_number)
            trig_snap <= status.trigger_number;
    end

    // the output register doubles as the lost count snapshot
    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
            bus_data_out <= '0;
        else if (bus_rd)
        begin
            case (bus_add)
                addr_soft_rst: bus_data_out <= tlu_version;
                addr_conf_mode,
                addr_conf_input,
                addr_low_timeout: bus_data_out <= regs[bus_add[$clog2(reg_count)-1:0]];
                addr_trigger_number: bus_data_out <= status.trigger_number[7:0];
                addr_trigger_number + 16'd1: bus_data_out <= trig_snap[15:8];
                addr_trigger_number + 16'd2: bus_data_out <= trig_snap[23:16];
                addr_trigger_number + 16'd3: bus_data_out <= trig_snap[31:24];
                addr_set_number,
                addr_set_number + 16'd1,
                addr_set_number + 16'd2,
                addr_set_number + 16'd3: bus_data_out <= regs[bus_add[$clog2(reg_count)-1:0]];
                addr_lost_count: bus_data_out <= status.lost_count;
                default: bus_data_out <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tlu_trigger_input.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlu_trigger_input import tlu_pkg::*;
(
    input wire BUS_CLK,
    input wire core_rst,
    input wire rj45_trigger,
    input wire lemo_trigger,
    input wire rj45_reset,
    input wire lemo_reset,
    input wire ext_veto,
    input wire tlu_conf_t conf,
    output logic rj45_enabled,
    output logic trigger_level,
    output logic trigger_flag,
    output logic tlu_reset_flag,
    output logic veto_level
);

    logic lemo_trigger_mod;
    logic [sync_stages-1:0][4:0] sync_q;
    logic rj45_trigger_s, lemo_trigger_s, rj45_reset_s, lemo_reset_s;
    logic reset_sel;
    logic trigger_q, reset_q;

    assign lemo_trigger_mod = conf.invert_lemo ? ~lemo_trigger : lemo_trigger;

    // all five pins share one shift chain
    always_ff @(posedge BUS_CLK)
    begin
        sync_q <= {sync_q[sync_stages-2:0],
                   {ext_veto, lemo_reset, rj45_reset, lemo_trigger_mod, rj45_trigger}};
    end

    assign {veto_level, lemo_reset_s, rj45_reset_s, lemo_trigger_s, rj45_trigger_s} =
        sync_q[sync_stages-1];

    // unplugged rj45 floats high on both lines so stay on lemo
    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
            rj45_enabled <= 1'b0;
        else if ((rj45_trigger_s && rj45_reset_s && !rj45_enabled) ||
                 (conf.mode == mode_disabled))
            rj45_enabled <= 1'b0;
        else
            rj45_enabled <= 1'b1;
    end

    assign trigger_level = rj45_enabled ? rj45_trigger_s : lemo_trigger_s;
    assign reset_sel = rj45_enabled ? rj45_reset_s : lemo_reset_s;

    // edge detect registers
    always_ff @(posedge BUS_CLK)
    begin
        trigger_q <= trigger_level;
        reset_q <= reset_sel;
    end

    assign trigger_flag = trigger_level & ~trigger_q;
    assign tlu_reset_flag = reset_sel & ~reset_q & conf.enable_reset;

endmodule

`default_nettype wire

// ==== verilog/tlu_trigger_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlu_trigger_fsm import tlu_pkg::*;
(
    input wire BUS_CLK,
    input wire core_rst,
    input wire tlu_conf_t conf,
    input wire [word_width-1:0] set_value,
    input wire trigger_level,
    input wire trigger_flag,
    input wire tlu_reset_flag,
    input wire veto_level,
    output logic tlu_busy,
    output logic [word_width-1:0] timestamp,
    output logic fifo_write,
    output logic [word_width-1:0] fifo_word,
    output logic [word_width-1:0] trigger_number
);

    trigger_state_e state;
    logic [7:0] low_cnt;
    logic handshake;
    logic veto;
    logic accept;

    assign handshake = (conf.mode == mode_simple_handshake) ||
                       (conf.mode == mode_handshake_alt);
    assign veto = veto_level && !conf.disable_veto;
    assign accept = trigger_flag && !veto && (conf.mode != mode_disabled) &&
                    (state == st_idle);

    // idle and vetoed also reads as busy towards the TLU
    assign tlu_busy = (state == st_wait_low) || ((state == st_idle) && handshake && veto);

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst || tlu_reset_flag)
            timestamp <= '0;
        else
            timestamp <= timestamp + 1'b1;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst || tlu_reset_flag)
            trigger_number <= '0;
        else if (conf.set_number_strobe)
            trigger_number <= set_value;
        else if (accept)
            trigger_number <= trigger_number + 1'b1;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
        begin
            state <= st_idle;
            low_cnt <= '0;
        end
        else
        begin
            case (state)
                st_idle:
                    if (accept && handshake)
                    begin
                        state <= st_wait_low;
                        low_cnt <= '0;
                    end
                st_wait_low:
                    if (!trigger_level)
                        state <= st_idle;
                    else if ((conf.low_timeout != 8'd0) && (low_cnt == conf.low_timeout))
                        state <= st_timeout_hold;
                    else
                        low_cnt <= low_cnt + 1'b1;
                // busy released until the line settles low
                st_timeout_hold:
                    if (!trigger_level)
                        state <= st_idle;
                default:
                    state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
            fifo_write <= 1'b0;
        else
            fifo_write <= accept;
    end

    // bit 31 marks a trigger word
    always_ff @(posedge BUS_CLK)
    begin
        if (accept)
            fifo_word <= {1'b1, conf.write_timestamp ? timestamp[word_width-2:0]
                                                     : trigger_number[word_width-2:0]};
    end

endmodule

`default_nettype wire

// ==== verilog/tlu_event_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlu_event_fifo import tlu_pkg::*;
(
    input wire BUS_CLK,
    input wire core_rst,
    input wire write,
    input wire [word_width-1:0] data_in,
    input wire read,
    output logic [word_width-1:0] data_out,
    output logic empty,
    output logic [7:0] lost_count
);

    logic [word_width-1:0] mem [fifo_depth];
    logic [fifo_addr_width-1:0] wr_ptr, rd_ptr;
    logic [fifo_addr_width:0] count;
    logic full;
    logic do_write, do_read;

    assign full = (count == (fifo_addr_width + 1)'(fifo_depth));
    assign empty = (count == '0);
    assign do_write = write && !full;
    assign do_read = read && !empty;

    // oldest word always on the output
    assign data_out = mem[rd_ptr];

    always_ff @(posedge BUS_CLK)
    begin
        if (do_write)
            mem[wr_ptr] <= data_in;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_write)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_read)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_write && !do_read)
                count <= count + 1'b1;
            else if (do_read && !do_write)
                count <= count - 1'b1;
        end
    end

    // saturates at 255
    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
            lost_count <= '0;
        else if (write && full && (lost_count != 8'hff))
            lost_count <= lost_count + 1'b1;
    end

endmodule

`default_nettype wire

// ==== verilog/tlu_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlu_controller import tlu_pkg::*;
(
    input wire BUS_CLK,
    input wire RST,
    input wire [addr_width-1:0] BUS_ADD,
    input wire [data_width-1:0] BUS_DATA_IN,
    input wire BUS_WR,
    input wire BUS_RD,
    output wire [data_width-1:0] BUS_DATA_OUT,
    input wire FIFO_READ,
    output wire FIFO_EMPTY,
    output wire [word_width-1:0] FIFO_DATA,
    input wire RJ45_TRIGGER,
    input wire LEMO_TRIGGER,
    input wire RJ45_RESET,
    input wire LEMO_RESET,
    input wire EXT_VETO,
    output wire RJ45_ENABLED,
    output wire TLU_BUSY,
    output wire [word_width-1:0] TIMESTAMP
);

    tlu_conf_t conf;
    wire tlu_status_t status;
    wire [word_width-1:0] set_value;
    wire core_rst;
    wire trigger_level, trigger_flag, tlu_reset_flag, veto_level;
    wire fifo_write;
    wire [word_width-1:0] fifo_word;

    tlu_bus_regs tlu_bus_regs_i (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .bus_add(BUS_ADD),
        .bus_data_in(BUS_DATA_IN),
        .bus_wr(BUS_WR),
        .bus_rd(BUS_RD),
        .bus_data_out(BUS_DATA_OUT),
        .status(status),
        .conf(conf),
        .set_value(set_value),
        .core_rst(core_rst)
    );

    tlu_trigger_input tlu_trigger_input_i (
        .BUS_CLK(BUS_CLK),
        .core_rst(core_rst),
        .rj45_trigger(RJ45_TRIGGER),
        .lemo_trigger(LEMO_TRIGGER),
        .rj45_reset(RJ45_RESET),
        .lemo_reset(LEMO_RESET),
        .ext_veto(EXT_VETO),
        .conf(conf),
        .rj45_enabled(RJ45_ENABLED),
        .trigger_level(trigger_level),
        .trigger_flag(trigger_flag),
        .tlu_reset_flag(tlu_reset_flag),
        .veto_level(veto_level)
    );

    tlu_trigger_fsm tlu_trigger_fsm_i (
        .BUS_CLK(BUS_CLK),
        .core_rst(core_rst),
        .conf(conf),
        .set_value(set_value),
        .trigger_level(trigger_level),
        .trigger_flag(trigger_flag),
        .tlu_reset_flag(tlu_reset_flag),
        .veto_level(veto_level),
        .tlu_busy(TLU_BUSY),
        .timestamp(TIMESTAMP),
        .fifo_write(fifo_write),
        .fifo_word(fifo_word),
        .trigger_number(status.trigger_number)
    );

    // lost count goes straight into the status bus
    tlu_event_fifo tlu_event_fifo_i (
        .BUS_CLK(BUS_CLK),
        .core_rst(core_rst),
        .write(fifo_write),
        .data_in(fifo_word),
        .read(FIFO_READ),
        .data_out(FIFO_DATA),
        .empty(FIFO_EMPTY),
        .lost_count(status.lost_count)
    );

endmodule

`default_nettype wire

// ==== bench/tb_tlu_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tlu_controller import tlu_pkg::*;
();

    localparam int max_cycles = 20000;
    localparam int sig_busy = 0;
    localparam int sig_rj45 = 1;
    localparam int sig_empty = 2;

    logic BUS_CLK = 1'b0;
    logic RST;
    logic [15:0] BUS_ADD;
    logic [7:0] BUS_DATA_IN;
    logic BUS_WR;
    logic BUS_RD;
    logic [7:0] BUS_DATA_OUT;
    logic FIFO_READ;
    logic FIFO_EMPTY;
    logic [31:0] FIFO_DATA;
    logic RJ45_TRIGGER;
    logic LEMO_TRIGGER;
    logic RJ45_RESET;
    logic LEMO_RESET;
    logic EXT_VETO;
    logic RJ45_ENABLED;
    logic TLU_BUSY;
    logic [31:0] TIMESTAMP;

    int errors = 0;
    int checks = 0;
    int cycle_count = 0;
    integer seed;
    logic [31:0] set_base;

    tlu_controller tlu_controller_i (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .BUS_ADD(BUS_ADD),
        .BUS_DATA_IN(BUS_DATA_IN),
        .BUS_WR(BUS_WR),
        .BUS_RD(BUS_RD),
        .BUS_DATA_OUT(BUS_DATA_OUT),
        .FIFO_READ(FIFO_READ),
        .FIFO_EMPTY(FIFO_EMPTY),
        .FIFO_DATA(FIFO_DATA),
        .RJ45_TRIGGER(RJ45_TRIGGER),
        .LEMO_TRIGGER(LEMO_TRIGGER),
        .RJ45_RESET(RJ45_RESET),
        .LEMO_RESET(LEMO_RESET),
        .EXT_VETO(EXT_VETO),
        .RJ45_ENABLED(RJ45_ENABLED),
        .TLU_BUSY(TLU_BUSY),
        .TIMESTAMP(TIMESTAMP)
    );

    always #4 BUS_CLK = ~BUS_CLK;

    // watchdog
    always @(posedge BUS_CLK)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == max_cycles)
        begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // marker bit on top of the 31 bit trigger number
    function automatic logic [31:0] event_word(input logic [31:0] number);
        return {1'b1, number[30:0]};
    endfunction

    function automatic int random_gap();
        return 4 + int'({$random(seed)} % 32'd8);
    endfunction

    function automatic logic probe(input int which);
        case (which)
            sig_busy: return TLU_BUSY;
            sig_rj45: return RJ45_ENABLED;
            default: return FIFO_EMPTY;
        endcase
    endfunction

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic wait_for(input int which, input logic level, input int limit,
                            input string what);
        int n;
        n = 0;
        @(negedge BUS_CLK);
        while ((probe(which) !== level) && (n < limit))
        begin
            @(negedge BUS_CLK);
            n++;
        end
        checks++;
        if (probe(which) !== level)
        begin
            errors++;
            $display("%s did not go to %b within %0d cycles", what, level, limit);
        end
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        BUS_ADD <= addr;
        BUS_DATA_IN <= data;
        BUS_WR <= 1'b1;
        @(posedge BUS_CLK);
        BUS_WR <= 1'b0;
    endtask

    // data is registered and sampled one cycle after the address
    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        @(posedge BUS_CLK);
        BUS_ADD <= addr;
        BUS_RD <= 1'b1;
        @(posedge BUS_CLK);
        BUS_RD <= 1'b0;
        @(negedge BUS_CLK);
        data = BUS_DATA_OUT;
    endtask

    task automatic set_trigger_number(input logic [31:0] value);
        for (int i = 0; i < 4; i++)
            bus_write(addr_set_number + 16'(i), value[8*i +: 8]);
        repeat (3) @(posedge BUS_CLK);
    endtask

    task automatic read_trigger_number(output logic [31:0] value);
        logic [7:0] b;
        for (int i = 0; i < 4; i++)
        begin
            bus_read(addr_trigger_number + 16'(i), b);
            value[8*i +: 8] = b;
        end
    endtask

    task automatic pulse_trigger(input logic use_rj45, input logic idle, input int width,
                                 input int gap);
        @(posedge BUS_CLK);
        if (use_rj45)
            RJ45_TRIGGER <= ~idle;
        else
            LEMO_TRIGGER <= ~idle;
        repeat (width) @(posedge BUS_CLK);
        if (use_rj45)
            RJ45_TRIGGER <= idle;
        else
            LEMO_TRIGGER <= idle;
        repeat (gap) @(posedge BUS_CLK);
    endtask

    // first word falls through and the read strobe removes it
    task automatic take_word(output logic [31:0] word);
        wait_for(sig_empty, 1'b0, 20, "FIFO_EMPTY");
        word = FIFO_DATA;
        @(posedge BUS_CLK);
        FIFO_READ <= 1'b1;
        @(posedge BUS_CLK);
        FIFO_READ <= 1'b0;
    endtask

    task automatic pop_word(input string what, input logic [31:0] exp);
        logic [31:0] w;
        take_word(w);
        check_equal(what, w, exp);
    endtask

    task automatic reset_defaults();
        logic [7:0] d;
        bus_read(addr_soft_rst, d);
        check_equal("version", 32'(d), 32'(tlu_version));
        @(negedge BUS_CLK);
        check_equal("FIFO_EMPTY after reset", 32'(FIFO_EMPTY), 32'd1);
        check_equal("TLU_BUSY after reset", 32'(TLU_BUSY), 32'd0);
        check_equal("RJ45_ENABLED after reset", 32'(RJ45_ENABLED), 32'd0);
        // mode field stays 0 so nothing gets accepted
        bus_write(addr_conf_mode, 8'ha4);
        bus_write(addr_conf_input, 8'h5a);
        bus_write(addr_low_timeout, 8'h3c);
        bus_read(addr_conf_mode, d);
        check_equal("reg 1", 32'(d), 32'h a4);
        bus_read(addr_conf_input, d);
        check_equal("reg 2", 32'(d), 32'h5a);
        bus_read(addr_low_timeout, d);
        check_equal("reg 3", 32'(d), 32'h3c);
        for (int a = 13; a < 16; a++)
            bus_write(16'(a), 8'hff);
        for (int a = 13; a < 16; a++)
        begin
            bus_read(16'(a), d);
            check_equal("unused address", 32'(d), 32'd0);
        end
        bus_write(addr_conf_input, 8'h00);
        bus_write(addr_low_timeout, 8'h00);
        bus_write(addr_conf_mode, 8'h00);
    endtask

    task automatic lemo_no_handshake();
        logic [31:0] num;
        set_base = $random(seed);
        bus_write(addr_conf_mode, 8'h01);
        set_trigger_number(set_base);
        for (int i = 0; i < 5; i++)
            pulse_trigger(1'b0, 1'b0, 2, random_gap());
        repeat (8) @(posedge BUS_CLK);
        for (int i = 0; i < 5; i++)
            pop_word("lemo word", event_word(set_base + 32'(i)));
        @(negedge BUS_CLK);
        check_equal("FIFO_EMPTY after five words", 32'(FIFO_EMPTY), 32'd1);
        read_trigger_number(num);
        check_equal("trigger number", num, set_base + 32'd5);
        check_equal("RJ45_ENABLED with cable unplugged", 32'(RJ45_ENABLED), 32'd0);
    endtask

    task automatic rj45_simple_handshake();
        @(posedge BUS_CLK);
        RJ45_TRIGGER <= 1'b0;
        RJ45_RESET <= 1'b0;
        wait_for(sig_rj45, 1'b1, 20, "RJ45_ENABLED");
        bus_write(addr_conf_mode, 8'h02);
        @(posedge BUS_CLK);
        RJ45_TRIGGER <= 1'b1;
        wait_for(sig_busy, 1'b1, 20, "TLU_BUSY");
        repeat (6) @(posedge BUS_CLK);
        @(negedge BUS_CLK);
        check_equal("TLU_BUSY while trigger high", 32'(TLU_BUSY), 32'd1);
        @(posedge BUS_CLK);
        RJ45_TRIGGER <= 1'b0;
        wait_for(sig_busy, 1'b0, 20, "TLU_BUSY");
        pop_word("handshake word", event_word(set_base + 32'd5));
        // vetoed trigger is dropped
        @(posedge BUS_CLK);
        EXT_VETO <= 1'b1;
        wait_for(sig_busy, 1'b1, 20, "TLU_BUSY under veto");
        pulse_trigger(1'b1, 1'b0, 2, 12);
        @(negedge BUS_CLK);
        check_equal("FIFO_EMPTY under veto", 32'(FIFO_EMPTY), 32'd1);
        check_equal("TLU_BUSY under veto", 32'(TLU_BUSY), 32'd1);
        bus_write(addr_conf_mode, 8'h0a);
        wait_for(sig_busy, 1'b0, 20, "TLU_BUSY with veto disabled");
        pulse_trigger(1'b1, 1'b0, 2, 12);
        pop_word("word with veto disabled", event_word(set_base + 32'd6));
        @(posedge BUS_CLK);
        EXT_VETO <= 1'b0;
        bus_write(addr_conf_mode, 8'h02);
    endtask

    task automatic fifo_overflow();
        logic [7:0] d;
        bus_write(addr_conf_mode, 8'h01);
        for (int i = 0; i < 10; i++)
            pulse_trigger(1'b1, 1'b0, 2, random_gap());
        repeat (8) @(posedge BUS_CLK);
        bus_read(addr_lost_count, d);
        check_equal("lost count", 32'(d), 32'd2);
        for (int i = 0; i < 8; i++)
            pop_word("drained word", event_word(set_base + 32'd7 + 32'(i)));
        @(negedge BUS_CLK);
        check_equal("FIFO_EMPTY after drain", 32'(FIFO_EMPTY), 32'd1);
    endtask

    task automatic lemo_tlu_reset();
        logic [31:0] num;
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] ts;
        // back to LEMO with the rj45 lines floating high
        bus_write(addr_conf_mode, 8'h00);
        @(posedge BUS_CLK);
        RJ45_TRIGGER <= 1'b1;
        RJ45_RESET <= 1'b1;
        wait_for(sig_rj45, 1'b0, 20, "RJ45_ENABLED");
        bus_write(addr_conf_input, 8'h60);
        @(posedge BUS_CLK);
        LEMO_TRIGGER <= 1'b1;
        repeat (8) @(posedge BUS_CLK);
        bus_write(addr_conf_mode, 8'h01);
        @(posedge BUS_CLK);
        LEMO_RESET <= 1'b1;
        repeat (2) @(posedge BUS_CLK);
        LEMO_RESET <= 1'b0;
        repeat (8) @(posedge BUS_CLK);
        @(negedge BUS_CLK);
        checks++;
        if (TIMESTAMP > 32'd16)
        begin
            errors++;
            $display("Mismatch at %0t ns: TIMESTAMP is %h, not cleared by the TLU reset",
                     $time, TIMESTAMP);
        end
        ts = TIMESTAMP;
        repeat (10) @(negedge BUS_CLK);
        check_equal("TIMESTAMP ten cycles later", TIMESTAMP, ts + 32'd10);
        read_trigger_number(num);
        check_equal("trigger number after TLU reset", num, 32'd0);
        pulse_trigger(1'b0, 1'b1, 2, 10);
        pop_word("first word after TLU reset", event_word(32'd0));
        bus_write(addr_conf_mode, 8'h81);
        pulse_trigger(1'b0, 1'b1, 2, random_gap());
        pulse_trigger(1'b0, 1'b1, 2, 12);
        take_word(first);
        take_word(second);
        check_equal("timestamp word marker", 32'(first[31]), 32'd1);
        check_equal("timestamp word marker", 32'(second[31]), 32'd1);
        checks++;
        if (second[30:0] <= first[30:0])
        begin
            errors++;
            $display("Mismatch at %0t ns: timestamps %h then %h do not increase",
                     $time, first, second);
        end
    endtask

    task automatic soft_reset_clear();
        logic [7:0] d;
        pulse_trigger(1'b0, 1'b1, 2, 10);
        wait_for(sig_empty, 1'b0, 20, "FIFO_EMPTY");
        bus_write(addr_low_timeout, 8'h5c);
        bus_write(addr_soft_rst, 8'h00);
        repeat (2) @(posedge BUS_CLK);
        bus_read(addr_conf_mode, d);
        check_equal("reg 1 after soft reset", 32'(d), 32'd0);
        bus_read(addr_conf_input, d);
        check_equal("reg 2 after soft reset", 32'(d), 32'd0);
        bus_read(addr_low_timeout, d);
        check_equal("reg 3 after soft reset", 32'(d), 32'd0);
        @(negedge BUS_CLK);
        check_equal("FIFO_EMPTY after soft reset", 32'(FIFO_EMPTY), 32'd1);
    endtask

    initial
    begin
        seed = 32'ha1b8_bf53;
        RST <= 1'b1;
        BUS_ADD <= '0;
        BUS_DATA_IN <= '0;
        BUS_WR <= 1'b0;
        BUS_RD <= 1'b0;
        FIFO_READ <= 1'b0;
        RJ45_TRIGGER <= 1'b1;
        RJ45_RESET <= 1'b1;
        LEMO_TRIGGER <= 1'b0;
        LEMO_RESET <= 1'b0;
        EXT_VETO <= 1'b0;
        repeat (16) @(posedge BUS_CLK);
        RST <= 1'b0;
        repeat (4) @(posedge BUS_CLK);

        reset_defaults();
        lemo_no_handshake();
        rj45_simple_handshake();
        fifo_overflow();
        lemo_tlu_reset();
        soft_reset_clear();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
verilog/tlu_pkg.sv
verilog/tlu_bus_regs.sv
verilog/tlu_trigger_input.sv
verilog/tlu_trigger_fsm.sv
verilog/tlu_event_fifo.sv
verilog/tlu_controller.sv
bench/tb_tlu_controller.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tb_tlu_controller -Mdir obj_dir -f filelist.f
	./obj_dir/Vtb_tlu_controller | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log
